// File: files.f
+incdir+.
sound_pkg.sv
sound_bus_decode.sv
sound_tone_regs.sv
sound_noise_regs.sv
sound_wave_regs.sv
sound_mix_regs.sv
sound_registers.sv
tb_sound_registers.sv

// File: run_sim.sh
#!/bin/bash
# Build the sound register testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f files.f --top-module tb_sound_registers -o tb_sim \
   && ./obj_dir/tb_sim | tee /dev/stderr | grep -qxF ">>> PASS" \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

// File: tb_sound_registers.sv
/* Testbench for the sound register file
 * Byte model of the register map and expected field structs
 * Bus write tasks, field assertions, test sequence
 * Clock, reset and watchdog
 */
`include "sound_params.svh"

module tb_sound_registers
   import sound_pkg::*;
();

   localparam int write_budget = 260; // Upper bound on bus writes of all tests

   logic           clk;
   logic           rst;
   sound_addr_t    addr;
   sound_byte_t    data;
   logic           w_enable;
   sound_tone_t    ch1;
   sound_tone_t    ch2;
   sound_wave_ch_t ch3;
   sound_noise_t   ch4;
   sound_mix_t     mix;
   sound_byte_t    model [256]; // Expected register bytes, by low address byte
   int             seed = 59;

   sound_registers sound_registers_i (
      .clk(clk), .rst(rst), .addr(addr), .data(data), .w_enable(w_enable),
      .ch1(ch1), .ch2(ch2), .ch3(ch3), .ch4(ch4), .mix(mix)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic sound_byte_t rand_byte();
      logic [31:0] r;
      r = $random(seed);
      return r[7:0];
   endfunction

   // Square channel fields, base is the low byte of NRx0
   function automatic sound_tone_t expect_tone(input sound_byte_t base, input bit has_sweep);
      sound_tone_t t;
      t = '0;
      if (has_sweep) begin
         t.sweep_time       = model[base][6:4];
         t.sweep_decreasing = model[base][3];
         t.sweep_shifts     = model[base][2:0];
      end
      t.duty           = model[base + 8'd1][7:6];
      t.length         = model[base + 8'd1][5:0];
      t.init_volume    = model[base + 8'd2][7:4];
      t.env_increasing = model[base + 8'd2][3];
      t.env_sweeps     = model[base + 8'd2][2:0];
      t.trigger        = model[base + 8'd4][7];
      t.dont_loop      = model[base + 8'd4][6];
      t.frequency      = {model[base + 8'd4][2:0], model[base + 8'd3]}; // Hi bits from NRx4
      return t;
   endfunction

   function automatic sound_wave_ch_t expect_wave();
      sound_wave_ch_t w;
      w = '0;
      w.enable       = model[8'h1A][7];
      w.length       = model[8'h1B];
      w.output_level = model[8'h1C][6:5];
      w.trigger      = model[8'h1E][7];
      w.dont_loop    = model[8'h1E][6];
      w.frequency    = {model[8'h1E][2:0], model[8'h1D]};
      // Shift in from FF30 on, first byte ends up on top
      for (int i = 0; i < `SOUND_WAVE_BYTES; i++) begin
         w.samples = {w.samples[`SOUND_WAVE_BYTES*8-9:0], model[8'h30 + i[7:0]]};
      end
      return w;
   endfunction

   function automatic sound_noise_t expect_noise();
      sound_noise_t n;
      n = '0;
      n.length         = model[8'h20][5:0];
      n.init_volume    = model[8'h21][7:4];
      n.env_increasing = model[8'h21][3];
      n.env_sweeps     = model[8'h21][2:0];
      n.shift_clock    = model[8'h22][7:4];
      n.counter_width  = model[8'h22][3];
      n.div_ratio      = model[8'h22][2:0];
      n.trigger        = model[8'h23][7];
      n.dont_loop      = model[8'h23][6];
      return n;
   endfunction

   function automatic sound_mix_t expect_mix();
      sound_mix_t m;
      m = '0;
      m.so2_vin       = model[8'h24][7];
      m.so2_level     = model[8'h24][6:4];
      m.so1_vin       = model[8'h24][3];
      m.so1_level     = model[8'h24][2:0];
      m.routing       = model[8'h25];
      m.master_enable = model[8'h26][`SOUND_MASTER_BIT];
      return m;
   endfunction

   // Register map as seen by the CPU, gaps at FF15 and FF1F
   function automatic void update_model(input sound_addr_t a, input sound_byte_t d);
      if (a == `SOUND_ADDR_NR52) begin
         if (!d[`SOUND_MASTER_BIT]) begin
            for (int i = 'h10; i < 'h26; i++) model[i[7:0]] = '0; // Sound off
         end
         model[8'h26] = {d[`SOUND_MASTER_BIT], 7'b0}; // Flag bits not kept
      end else if (a >= `SOUND_WAVE_BASE &&
                   a <= sound_addr_t'(`SOUND_WAVE_BASE + `SOUND_WAVE_BYTES - 1)) begin
         model[a[7:0]] = d; // Wave RAM ignores the master enable
      end else if (model[8'h26][`SOUND_MASTER_BIT] &&
                   ((a >= `SOUND_ADDR_NR10 && a <= `SOUND_ADDR_NR14) ||
                    (a >= `SOUND_ADDR_NR21 && a <= `SOUND_ADDR_NR34) ||
                    (a >= `SOUND_ADDR_NR41 && a <= `SOUND_ADDR_NR51))) begin
         model[a[7:0]] = d;
      end
   endfunction

   task automatic compare_value(input string test, input string field,
                                input logic [159:0] expected, input logic [159:0] actual);
      assert (actual === expected) else begin
         $display("[ERROR] %s: %s expected %0h actual %0h", test, field, expected, actual);
         $display(">>> FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_all(input string test);
      sound_wave_ch_t exp3;
      sound_wave_ch_t act3;
      exp3 = expect_wave();
      act3 = ch3;
      compare_value(test, "ch1", 160'(expect_tone(8'h10, 1'b1)), 160'(ch1));
      compare_value(test, "ch2", 160'(expect_tone(8'h15, 1'b0)), 160'(ch2)); // NR20 slot empty
      compare_value(test, "ch3 samples", 160'(exp3.samples), 160'(act3.samples));
      exp3.samples = '0;
      act3.samples = '0;
      compare_value(test, "ch3 control", 160'(exp3), 160'(act3));
      compare_value(test, "ch4", 160'(expect_noise()), 160'(ch4));
      compare_value(test, "mix", 160'(expect_mix()), 160'(mix));
   endtask

   // One strobe cycle, then check mid-cycle after the capture edge
   task automatic write_check(input string test, input sound_addr_t a, input sound_byte_t d);
      @(posedge clk);
      addr     <= a;
      data     <= d;
      w_enable <= 1'b1;
      @(posedge clk);
      w_enable <= 1'b0;
      update_model(a, d);
      @(negedge clk);
      check_all(test);
   endtask

   task automatic write_span(input string test, input sound_addr_t first, input sound_addr_t last);
      sound_addr_t a;
      a = first;
      while (a <= last) begin
         write_check(test, a, rand_byte());
         a = a + 16'd1;
      end
   endtask

   initial begin
      rst      = 1'b1;
      addr     = '0;
      data     = '0;
      w_enable = 1'b0;
      model    = '{default: '0};
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_all("reset");

      write_check("master_on", `SOUND_ADDR_NR52, 8'h80);
      repeat (4) write_span("tone", `SOUND_ADDR_NR10, `SOUND_ADDR_NR24); // Includes FF15
      repeat (4) begin
         write_span("wave_noise_mix", `SOUND_ADDR_NR30, `SOUND_ADDR_NR34);
         write_span("wave_noise_mix", `SOUND_ADDR_NR41, `SOUND_ADDR_NR51);
      end
      write_span("wave_ram", `SOUND_WAVE_BASE, sound_addr_t'(`SOUND_WAVE_BASE + 15));

      // Sound off, then on again
      write_check("sound_off", `SOUND_ADDR_NR52, rand_byte() & 8'h7F);
      write_span("off_ignored", `SOUND_ADDR_NR10, `SOUND_ADDR_NR51);
      write_span("off_wave_ram", `SOUND_WAVE_BASE, sound_addr_t'(`SOUND_WAVE_BASE + 15));
      write_check("sound_on", `SOUND_ADDR_NR52, rand_byte() | 8'h80);
      write_span("re_enabled", `SOUND_ADDR_NR10, `SOUND_ADDR_NR51);

      write_span("unmapped", 16'hFF27, 16'hFF2F);
      write_check("unmapped", 16'hFF15, rand_byte());
      write_check("unmapped", 16'hFF1F, rand_byte());
      write_check("unmapped", 16'hFF0F, rand_byte());
      write_check("unmapped", 16'hFF40, rand_byte());
      repeat (16) write_check("unmapped", {rand_byte() & 8'hFE, rand_byte()}, rand_byte());
      // Bus busy but no strobe
      repeat (20) begin
         @(posedge clk);
         addr     <= {8'hFF, rand_byte()};
         data     <= rand_byte();
         w_enable <= 1'b0;
         @(negedge clk);
         check_all("no_enable");
      end

      $display(">>> PASS");
      $finish;
   end

   initial begin
      repeat (write_budget * 10 + 100) @(posedge clk);
      $display("Watchdog expired before the tests finished");
      $display(">>> FAIL");
      $fatal(1, "Timeout");
   end

endmodule

// File: sound_registers.sv
/* Sound unit register file, top level
 * Bus decoder feeding two tone blocks, noise, wave and mixer blocks
 * One field struct per channel plus the mixer
 */

module sound_registers
   import sound_pkg::*;
(
   input  logic           clk,
   input  logic           rst,
   input  sound_addr_t    addr,
   input  sound_byte_t    data,
   input  logic           w_enable,
   output sound_tone_t    ch1,
   output sound_tone_t    ch2,
   output sound_wave_ch_t ch3,
   output sound_noise_t   ch4,
   output sound_mix_t     mix
);

   tone_wr_t  ch1_wr;
   tone_wr_t  ch2_wr;
   noise_wr_t noise_wr;
   wave_wr_t  wave_wr;
   mix_wr_t   mix_wr;
   logic      clear;          // Sound-off pulse
   logic      master_enable;  // From NR52

   sound_bus_decode sound_bus_decode_i (
      .addr          (addr),
      .data          (data),
      .w_enable      (w_enable),
      .master_enable (master_enable),
      .ch1_wr        (ch1_wr),
      .ch2_wr        (ch2_wr),
      .noise_wr      (noise_wr),
      .wave_wr       (wave_wr),
      .mix_wr        (mix_wr),
      .clear         (clear)
   );

   // Channel 1 with sweep
   sound_tone_regs #(.HAS_SWEEP(1)) ch1_regs_i (
      .clk(clk), .rst(rst), .clear(clear), .wr(ch1_wr), .data(data), .regs(ch1)
   );

   sound_tone_regs #(.HAS_SWEEP(0)) ch2_regs_i ( // No NR20
      .clk(clk), .rst(rst), .clear(clear), .wr(ch2_wr), .data(data), .regs(ch2)
   );

   sound_wave_regs ch3_regs_i (
      .clk(clk), .rst(rst), .clear(clear), .wr(wave_wr), .data(data), .regs(ch3)
   );

   sound_noise_regs ch4_regs_i (
      .clk(clk), .rst(rst), .clear(clear), .wr(noise_wr), .data(data), .regs(ch4)
   );

   sound_mix_regs mix_regs_i (
      .clk           (clk),
      .rst           (rst),
      .clear         (clear),
      .wr            (mix_wr),
      .data          (data),
      .regs          (mix),
      .master_enable (master_enable)
   );

endmodule

// File: sound_mix_regs.sv
/* Mixer and master registers
 * NR50 master volume and Vin, NR51 terminal routing
 * NR52 master enable bit, fed back to the decoder
 */
`include "sound_params.svh"

module sound_mix_regs
   import sound_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  mix_wr_t     wr,
   input  sound_byte_t data,
   output sound_mix_t  regs,
   output logic        master_enable
);

   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '0;
      end else begin
         if (clear) begin
            regs.so2_vin   <= 1'b0;
            regs.so2_level <= '0;
            regs.so1_vin   <= 1'b0;
            regs.so1_level <= '0;
            regs.routing   <= '0;
         end else begin
            if (wr.vol) begin
               {regs.so2_vin, regs.so2_level, regs.so1_vin, regs.so1_level} <= data;
            end
            if (wr.route) regs.routing <= data; // One bit per channel/terminal
         end
         // On-flags in bits 3-0 are status, not stored
         if (wr.ctrl) regs.master_enable <= data[`SOUND_MASTER_BIT];
      end
   end

   assign master_enable = regs.master_enable;

endmodule

// File: sound_wave_regs.sv
/* Wave channel registers
 * NR30-NR34 control fields
 * 16-byte wave pattern RAM, untouched by sound-off clear
 */
`include "sound_params.svh"

module sound_wave_regs
   import sound_pkg::*;
(
   input  logic           clk,
   input  logic           rst,
   input  logic           clear,
   input  wave_wr_t       wr,
   input  sound_byte_t    data,
   output sound_wave_ch_t regs
);

   // Pattern RAM kept in the samples field, FF30 in the top byte
   always_ff @(posedge clk) begin
      if (rst) begin
         regs <= '0;
      end else begin
         if (clear) begin // Control fields only
            regs.enable       <= 1'b0;
            regs.length       <= '0;
            regs.output_level <= '0;
            regs.trigger      <= 1'b0;
            regs.dont_loop    <= 1'b0;
            regs.frequency    <= '0;
         end else begin
            if (wr.on)      regs.enable         <= data[7];
            if (wr.len)     regs.length         <= data;
            if (wr.level)   regs.output_level   <= data[6:5];
            if (wr.freq_lo) regs.frequency[7:0] <= data;
            if (wr.freq_hi) begin
               regs.trigger         <= data[7];
               regs.dont_loop       <= data[6];
               regs.frequency[10:8] <= data[2:0];
            end
         end
         // RAM bytes survive sound off
         if (wr.ram) begin
            regs.samples[(`SOUND_WAVE_BYTES - 1 - wr.ram_idx) * 8 +: 8] <= data;
         end
      end
   end

endmodule

// File: sound_noise_regs.sv
/* Noise channel registers
 * NR41 length, NR42 envelope
 * NR43 polynomial counter, NR44 control
 */

module sound_noise_regs
   import sound_pkg::*;
(
   input  logic         clk,
   input  logic         rst,
   input  logic         clear,
   input  noise_wr_t    wr,
   input  sound_byte_t  data,
   output sound_noise_t regs
);

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         regs <= '0;
      end else begin
         if (wr.len) begin
            regs.length <= data[5:0]; // Top two bits unused
         end
         if (wr.env) begin
            regs.init_volume    <= data[7:4];
            regs.env_increasing <= data[3];
            regs.env_sweeps     <= data[2:0];
         end
         // Shift clock, LFSR width, divider
         if (wr.poly) begin
            regs.shift_clock   <= data[7:4];
            regs.counter_width <= data[3];
            regs.div_ratio     <= data[2:0];
         end
         if (wr.ctrl) begin
            regs.trigger   <= data[7];
            regs.dont_loop <= data[6];
         end
      end
   end

endmodule

// File: sound_tone_regs.sv
/* Square wave channel registers
 * Sweep (ch1 only), length/duty, envelope, frequency lo/hi
 * Fields kept unpacked in the output struct
 */

module sound_tone_regs
   import sound_pkg::*;
#(
   parameter int HAS_SWEEP = 1 // 1 for ch1, 0 for ch2
) (
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  tone_wr_t    wr,
   input  sound_byte_t data,
   output sound_tone_t regs
);

   always_ff @(posedge clk) begin
      if (rst || clear) begin
         regs <= '0;
      end else begin
         // NR10, absent on ch2 so fields hold reset value
         if ((HAS_SWEEP != 0) && wr.sweep) begin
            regs.sweep_time       <= data[6:4];
            regs.sweep_decreasing <= data[3];
            regs.sweep_shifts     <= data[2:0];
         end

         if (wr.len_duty) begin // NR11/NR21
            regs.duty   <= data[7:6];
            regs.length <= data[5:0];
         end

         if (wr.env) begin // NR12/NR22
            regs.init_volume    <= data[7:4];
            regs.env_increasing <= data[3];
            regs.env_sweeps     <= data[2:0];
         end

         // Low byte of 11-bit frequency
         if (wr.freq_lo) begin
            regs.frequency[7:0] <= data;
         end

         if (wr.freq_hi) begin // NR14/NR24
            regs.trigger         <= data[7]; // Kept as level
            regs.dont_loop       <= data[6];
            regs.frequency[10:8] <= data[2:0]; // Bits 5-3 unused
         end
      end
   end

endmodule

// File: sound_bus_decode.sv
/* Sound bus decoder
 * Address compare against NR10-NR52 and the wave RAM window
 * One-hot write strobes per register block
 * Master enable gating and NR52 clear pulse
 */
`include "sound_params.svh"

module sound_bus_decode
   import sound_pkg::*;
(
   input  sound_addr_t addr,
   input  sound_byte_t data,
   input  logic        w_enable,
   input  logic        master_enable,
   output tone_wr_t    ch1_wr,
   output tone_wr_t    ch2_wr,
   output noise_wr_t   noise_wr,
   output wave_wr_t    wave_wr,
   output mix_wr_t     mix_wr,
   output logic        clear
);

   sound_addr_t wave_off;
   logic        wave_hit;

   // Below the base wraps to a large offset, so one compare covers the window
   assign wave_off = addr - `SOUND_WAVE_BASE;
   assign wave_hit = wave_off < sound_addr_t'(`SOUND_WAVE_BYTES);

   always_comb begin
      ch1_wr   = '0;
      ch2_wr   = '0;
      noise_wr = '0;
      wave_wr  = '0;
      mix_wr   = '0;
      wave_wr.ram_idx = sound_widx_t'(wave_off); // Low address bits
      if (w_enable) begin
         // Register strobes follow the master enable
         case (addr)
            `SOUND_ADDR_NR10: ch1_wr.sweep      = master_enable;
            `SOUND_ADDR_NR11: ch1_wr.len_duty   = master_enable;
            `SOUND_ADDR_NR12: ch1_wr.env        = master_enable;
            `SOUND_ADDR_NR13: ch1_wr.freq_lo    = master_enable;
            `SOUND_ADDR_NR14: ch1_wr.freq_hi    = master_enable;
            `SOUND_ADDR_NR21: ch2_wr.len_duty   = master_enable;
            `SOUND_ADDR_NR22: ch2_wr.env        = master_enable;
            `SOUND_ADDR_NR23: ch2_wr.freq_lo    = master_enable;
            `SOUND_ADDR_NR24: ch2_wr.freq_hi    = master_enable;
            `SOUND_ADDR_NR30: wave_wr.on        = master_enable;
            `SOUND_ADDR_NR31: wave_wr.len       = master_enable;
            `SOUND_ADDR_NR32: wave_wr.level     = master_enable;
            `SOUND_ADDR_NR33: wave_wr.freq_lo   = master_enable;
            `SOUND_ADDR_NR34: wave_wr.freq_hi   = master_enable;
            `SOUND_ADDR_NR41: noise_wr.len      = master_enable;
            `SOUND_ADDR_NR42: noise_wr.env      = master_enable;
            `SOUND_ADDR_NR43: noise_wr.poly     = master_enable;
            `SOUND_ADDR_NR44: noise_wr.ctrl     = master_enable;
            `SOUND_ADDR_NR50: mix_wr.vol        = master_enable;
            `SOUND_ADDR_NR51: mix_wr.route      = master_enable;
            `SOUND_ADDR_NR52: mix_wr.ctrl       = 1'b1; // Always reachable
            default: ;                                  // FF15, FF1F, FF27.. ignored
         endcase
         // Wave RAM stays writable with sound off
         wave_wr.ram = wave_hit;
      end
   end

   // Turning sound off wipes every register but the wave RAM
   assign clear = w_enable && (addr == `SOUND_ADDR_NR52) && !data[`SOUND_MASTER_BIT];

endmodule

// File: sound_pkg.sv
/* Sound unit shared types
 * Field widths of the register map
 * Per-channel and mixer field structs
 * Per-block write strobe structs
 */
`include "sound_params.svh"

package sound_pkg;

   typedef logic [15:0] sound_addr_t; // CPU address bus
   typedef logic [7:0]  sound_byte_t; // Data bus, raw register
   typedef logic [10:0] sound_freq_t; // Channel frequency code
   typedef logic [3:0]  sound_vol_t;  // Envelope start volume
   typedef logic [5:0]  sound_len6_t; // Length of ch1, ch2, ch4
   typedef logic [`SOUND_WAVE_BYTES*8-1:0] sound_wave_t; // All samples
   typedef logic [$clog2(`SOUND_WAVE_BYTES)-1:0] sound_widx_t; // Wave RAM byte index

   // Square wave channel, NR10-NR14 or NR21-NR24
   typedef struct packed {
      logic [2:0]  sweep_time;      // 0 turns sweep off
      logic        sweep_decreasing;
      logic [2:0]  sweep_shifts;
      logic [1:0]  duty;            // 12.5, 25, 50, 75 percent
      sound_len6_t length;
      sound_vol_t  init_volume;
      logic        env_increasing;
      logic [2:0]  env_sweeps;      // 0 stops envelope
      logic        trigger;         // Restart, stored level
      logic        dont_loop;       // Stop when length expires
      sound_freq_t frequency;
   } sound_tone_t;

   // Noise channel, NR41-NR44
   typedef struct packed {
      sound_len6_t length;
      sound_vol_t  init_volume;
      logic        env_increasing;
      logic [2:0]  env_sweeps;
      logic [3:0]  shift_clock;     // Polynomial counter shift
      logic        counter_width;   // 1 selects 7-bit LFSR
      logic [2:0]  div_ratio;
      logic        trigger;
      logic        dont_loop;
   } sound_noise_t;

   // Wave channel, NR30-NR34 plus pattern RAM
   typedef struct packed {
      logic        enable;          // Playback on
      sound_byte_t length;          // Full 8-bit length
      logic [1:0]  output_level;    // Mute, 100, 50, 25 percent
      logic        trigger;
      logic        dont_loop;
      sound_freq_t frequency;
      sound_wave_t samples;         // FF30 in top byte
   } sound_wave_ch_t;

   // Mixer, NR50-NR52
   typedef struct packed {
      logic        so2_vin;
      logic [2:0]  so2_level;
      logic        so1_vin;
      logic [2:0]  so1_level;
      sound_byte_t routing;         // SO2 ch4..ch1, SO1 ch4..ch1
      logic        master_enable;
   } sound_mix_t;

   typedef struct packed {
      logic sweep;
      logic len_duty;
      logic env;
      logic freq_lo;
      logic freq_hi;
   } tone_wr_t;

   typedef struct packed {
      logic len;
      logic env;
      logic poly;
      logic ctrl;
   } noise_wr_t;

   typedef struct packed {
      logic        on;
      logic        len;
      logic        level;
      logic        freq_lo;
      logic        freq_hi;
      logic        ram;
      sound_widx_t ram_idx;
   } wave_wr_t;

   typedef struct packed {
      logic vol;
      logic route;
      logic ctrl;
   } mix_wr_t;

endpackage

// File: sound_params.svh
/* Sound unit register map
 * Bus addresses of NR10-NR52
 * Wave pattern RAM window and size
 * Master enable bit position in NR52
 */
`ifndef SOUND_PARAMS_SVH
`define SOUND_PARAMS_SVH

// Channel 1, tone with sweep
`define SOUND_ADDR_NR10 16'hFF10
`define SOUND_ADDR_NR11 16'hFF11
`define SOUND_ADDR_NR12 16'hFF12
`define SOUND_ADDR_NR13 16'hFF13
`define SOUND_ADDR_NR14 16'hFF14
// Channel 2, tone only (FF15 unmapped)
`define SOUND_ADDR_NR21 16'hFF16
`define SOUND_ADDR_NR22 16'hFF17
`define SOUND_ADDR_NR23 16'hFF18
`define SOUND_ADDR_NR24 16'hFF19
`define SOUND_ADDR_NR30 16'hFF1A // Channel 3, wave output
`define SOUND_ADDR_NR31 16'hFF1B
`define SOUND_ADDR_NR32 16'hFF1C
`define SOUND_ADDR_NR33 16'hFF1D
`define SOUND_ADDR_NR34 16'hFF1E
`define SOUND_ADDR_NR41 16'hFF20 // Channel 4, noise (FF1F unmapped)
`define SOUND_ADDR_NR42 16'hFF21
`define SOUND_ADDR_NR43 16'hFF22
`define SOUND_ADDR_NR44 16'hFF23
`define SOUND_ADDR_NR50 16'hFF24 // Master volume, Vin
`define SOUND_ADDR_NR51 16'hFF25 // Terminal routing
`define SOUND_ADDR_NR52 16'hFF26 // Master on/off
`define SOUND_WAVE_BASE  16'hFF30 // First wave RAM byte
`define SOUND_WAVE_BYTES 16 // 32 four-bit samples
`define SOUND_MASTER_BIT 7

`endif
